// ==== vlog.f ====
source/mem_pkg.sv
source/mem_port_mux.sv
source/mem_bus_delay.sv
source/mem_core.sv
source/mem_subsystem.sv
verification/mem_subsystem_chk.sv
verification/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --assert -j 0 --top-module mem_subsystem_tb \
    -f vlog.f -o sim_mem_subsystem > "$build_log" 2>&1 \
    || { cat "$build_log"; echo "build failed"; exit 1; }

./obj_dir/sim_mem_subsystem > "$sim_log" 2>&1 \
    || { cat "$sim_log"; echo "simulation stopped with an error"; exit 1; }

cat "$sim_log"

grep -qF '*** FAILED ***' "$sim_log" \
    && { echo "simulation failed"; exit 1; } \
    || echo "simulation passed"

// ==== verification/mem_subsystem_tb.sv ====
module mem_subsystem_tb;

    localparam int latency    = 3;
    localparam int test_count = 6;
    localparam int op_idle    = 0;
    localparam int op_read    = 1;
    localparam int op_write   = 2;

    logic                clock;
    logic                reset;
    logic                instr_read;
    logic                instr_write;
    mem_pkg::line_addr_t instr_addr;
    mem_pkg::line_t      instr_wdata;
    logic                instr_busy;
    logic                instr_resp_valid;
    mem_pkg::line_addr_t instr_resp_addr;
    mem_pkg::line_t      instr_resp_data;
    logic                data_read;
    logic                data_write;
    mem_pkg::line_addr_t data_addr;
    mem_pkg::line_t      data_wdata;
    logic                data_busy;
    logic                data_resp_valid;
    mem_pkg::line_addr_t data_resp_addr;
    mem_pkg::line_t      data_resp_data;

    // stimulus table, one entry per cycle
    int                     tab_test [$];
    mem_pkg::requester_id_t tab_port [$];
    int                     tab_op   [$];
    mem_pkg::line_addr_t    tab_addr [$];
    bit                     tab_pair [$];  // issued together with the next entry

    string test_name   [test_count];
    int    test_last   [test_count];  // index of the last entry of each test
    int    test_errors [test_count];
    int    outstanding [test_count];  // reads still waiting for a response

    // reference memory and expected responses, indexed by requester id
    mem_pkg::line_t      ref_mem  [mem_pkg::line_count];
    mem_pkg::line_addr_t exp_addr [2][$];
    mem_pkg::line_t      exp_data [2][$];
    int                  exp_due  [2][$];
    int                  exp_test [2][$];

    int seed        = 19;
    int cycle_count = 0;
    int busy_due    = -10;  // cycle in which instr_busy must be high
    int issued_upto = 0;
    int next_report = 0;
    int check_test  = 0;
    int check_count = 0;
    int error_count = 0;

    mem_subsystem #(
        .MEM_LATENCY (latency)
    ) mem_subsystem_i (.*);

    initial begin : clock_gen
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic note_error();
        error_count++;
        test_errors[check_test]++;
    endtask

    task automatic compare_line(input string name, input mem_pkg::line_t expected,
                                input mem_pkg::line_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            note_error();
        end
    endtask

    task automatic compare_addr(input string name, input mem_pkg::line_addr_t expected,
                                input mem_pkg::line_addr_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            note_error();
        end
    endtask

    task automatic compare_flag(input string name, input bit expected, input bit actual);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0b actual %0b", $time, name, expected, actual);
            note_error();
        end
    endtask

    function automatic int report_test();
        if (next_report < test_count) begin
            return next_report;
        end
        return test_count - 1;
    endfunction

    function automatic mem_pkg::line_t random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic bit port_busy(input mem_pkg::requester_id_t port);
        if (port == mem_pkg::instr_id) begin
            return instr_busy;
        end
        return data_busy;
    endfunction

    task automatic add_step(input int test, input mem_pkg::requester_id_t port, input int op,
                            input mem_pkg::line_addr_t addr, input bit pair);
        tab_test.push_back(test);
        tab_port.push_back(port);
        tab_op.push_back(op);
        tab_addr.push_back(addr);
        tab_pair.push_back(pair);
        test_last[test] = tab_port.size() - 1;
    endtask

    task automatic build_table();
        test_name[0] = "idle after reset";
        test_name[1] = "data writes then reads";
        test_name[2] = "instr read latency";
        test_name[3] = "same-cycle reads";
        test_name[4] = "alternating reads";
        test_name[5] = "write then read on other port";
        repeat (3) add_step(0, mem_pkg::data_id, op_idle, 8'h00, 1'b0);
        add_step(1, mem_pkg::data_id, op_write, 8'h10, 1'b0);
        add_step(1, mem_pkg::data_id, op_write, 8'h22, 1'b0);
        add_step(1, mem_pkg::data_id, op_write, 8'h37, 1'b0);
        add_step(1, mem_pkg::data_id, op_write, 8'hc4, 1'b0);
        add_step(1, mem_pkg::data_id, op_read, 8'h10, 1'b0);
        add_step(1, mem_pkg::data_id, op_read, 8'h22, 1'b0);
        add_step(1, mem_pkg::data_id, op_read, 8'h37, 1'b0);
        add_step(1, mem_pkg::data_id, op_read, 8'hc4, 1'b0);
        add_step(2, mem_pkg::instr_id, op_read, 8'h22, 1'b0);
        add_step(3, mem_pkg::data_id, op_read, 8'h10, 1'b1);  // data wins the pair
        add_step(3, mem_pkg::instr_id, op_read, 8'h37, 1'b0);
        add_step(4, mem_pkg::data_id, op_read, 8'h10, 1'b0);
        add_step(4, mem_pkg::instr_id, op_read, 8'hc4, 1'b0);
        add_step(4, mem_pkg::data_id, op_read, 8'h22, 1'b0);
        add_step(4, mem_pkg::instr_id, op_read, 8'h10, 1'b0);
        add_step(4, mem_pkg::data_id, op_read, 8'h37, 1'b0);
        add_step(4, mem_pkg::instr_id, op_read, 8'h22, 1'b0);
        add_step(5, mem_pkg::data_id, op_write, 8'h5a, 1'b0);
        add_step(5, mem_pkg::instr_id, op_read, 8'h5a, 1'b0);
        add_step(5, mem_pkg::instr_id, op_write, 8'h81, 1'b0);
        add_step(5, mem_pkg::data_id, op_read, 8'h81, 1'b0);
    endtask

    task automatic drive_idle();
        instr_read  <= 1'b0;
        instr_write <= 1'b0;
        data_read   <= 1'b0;
        data_write  <= 1'b0;
    endtask

    // drives one entry and records what the memory must answer
    task automatic apply_entry(input int idx, input bit paired);
        mem_pkg::line_t line;
        bit             held;
        int             port;
        held = paired && (tab_port[idx] == mem_pkg::instr_id);
        port = int'(tab_port[idx]);
        if (tab_op[idx] == op_idle) begin
            return;
        end
        if (tab_op[idx] == op_write) begin
            line = random_line();
            ref_mem[tab_addr[idx]] = line;
        end else begin
            line = ref_mem[tab_addr[idx]];
            exp_addr[port].push_back(tab_addr[idx]);
            exp_data[port].push_back(line);
            exp_due[port].push_back(cycle_count + 2 * latency + 3 + int'(held));
            exp_test[port].push_back(tab_test[idx]);
            outstanding[tab_test[idx]]++;
        end
        if (held) begin
            busy_due = cycle_count + 2;  // hold register fills at the next edge
        end
        if (port == 0) begin
            instr_read  <= (tab_op[idx] == op_read);
            instr_write <= (tab_op[idx] == op_write);
            instr_addr  <= tab_addr[idx];
            instr_wdata <= line;
        end else begin
            data_read  <= (tab_op[idx] == op_read);
            data_write <= (tab_op[idx] == op_write);
            data_addr  <= tab_addr[idx];
            data_wdata <= line;
        end
    endtask

    task automatic check_port(input int port, input bit valid,
                              input mem_pkg::line_addr_t addr, input mem_pkg::line_t data);
        bit    due;
        string side;
        if (port == 0) begin
            side = "instr";
        end else begin
            side = "data";
        end
        due = (exp_due[port].size() > 0) && (exp_due[port][0] == cycle_count);
        check_test = due ? exp_test[port][0] : report_test();
        if (due && !valid) begin
            $display("%0t: %s read of line %h got no response in cycle %0d",
                     $time, side, exp_addr[port][0], cycle_count);
            note_error();
        end else begin
            compare_flag({side, "_resp_valid"}, due, valid);
            if (due) begin
                compare_addr({side, "_resp_addr"}, exp_addr[port][0], addr);
                compare_line({side, "_resp_data"}, exp_data[port][0], data);
            end
        end
        if (due) begin
            outstanding[exp_test[port][0]]--;
            void'(exp_addr[port].pop_front());
            void'(exp_data[port].pop_front());
            void'(exp_due[port].pop_front());
            void'(exp_test[port].pop_front());
        end
    endtask

    initial begin : monitor
        forever begin
            @(negedge clock);
            if (!reset) begin
                check_port(0, instr_resp_valid, instr_resp_addr, instr_resp_data);
                check_port(1, data_resp_valid, data_resp_addr, data_resp_data);
                check_test = report_test();
                compare_flag("instr_busy", cycle_count == busy_due, instr_busy);
                compare_flag("data_busy", 1'b0, data_busy);
                while (next_report < test_count && test_last[next_report] < issued_upto
                       && outstanding[next_report] == 0) begin
                    $display("test %0d %s finished with %0d errors",
                             next_report, test_name[next_report], test_errors[next_report]);
                    next_report++;
                end
            end
        end
    end

    initial begin : watchdog
        @(negedge reset);
        repeat (tab_port.size() + 2 * latency + 20) @(posedge clock);
        $display("timeout, %0d of %0d tests never finished", test_count - next_report, test_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int idx;
        bit hold_guard;
        bit wait_busy;
        reset       = 1'b1;
        instr_read  = 1'b0;
        instr_write = 1'b0;
        instr_addr  = '0;
        instr_wdata = '0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        build_table();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        idx        = 0;
        hold_guard = 1'b0;
        while (idx < tab_port.size()) begin
            @(negedge clock);
            // a pair just issued raises instr_busy only at the coming edge
            wait_busy = hold_guard || (tab_op[idx] != op_idle && port_busy(tab_port[idx]))
                        || (tab_pair[idx] && port_busy(tab_port[idx+1]));
            @(posedge clock);
            drive_idle();
            hold_guard = 1'b0;
            if (!wait_busy) begin
                if (tab_pair[idx]) begin
                    apply_entry(idx, 1'b1);
                    apply_entry(idx + 1, 1'b1);
                    hold_guard = 1'b1;
                    idx += 2;
                end else begin
                    apply_entry(idx, 1'b0);
                    idx++;
                end
                issued_upto = idx;
            end
        end
        @(posedge clock);
        drive_idle();
        while (next_report < test_count) @(posedge clock);
        repeat (3) @(posedge clock);  // room for a stray response
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/mem_subsystem_chk.sv ====
module mem_subsystem_chk #(
    parameter bit check_busy = 1'b0,  // instance watches instr_busy
    parameter bit check_core = 1'b0   // instance watches the core handshake
) (
    input logic clock,
    input logic reset,
    input logic req_read,   // request strobes on the watched bus
    input logic req_write,
    input logic busy,
    input logic rd_issue,   // read entering the core
    input logic rd_resp     // core answer
);

    // one operation per request
    read_write_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(req_read && req_write)
    ) else $error("read and write strobes high in the same cycle");

    if (check_busy) begin : busy_check
        busy_single_cycle: assert property (
            @(posedge clock) disable iff (reset) busy |=> !busy
        ) else $error("instr_busy stayed high for more than one cycle");
    end

    // core answers on the next cycle
    if (check_core) begin : core_check
        read_answered: assert property (
            @(posedge clock) disable iff (reset) rd_issue |=> rd_resp
        ) else $error("core read not answered on the next cycle");
    end

endmodule

bind mem_port_mux mem_subsystem_chk #(
    .check_busy (1'b1)
) mux_chk_i (
    .clock     (clock),
    .reset     (reset),
    .req_read  (bus_req_read),
    .req_write (bus_req_write),
    .busy      (instr_busy),
    .rd_issue  (1'b0),
    .rd_resp   (1'b0)
);

bind mem_bus_delay mem_subsystem_chk #(
    .check_core (1'b1)
) delay_chk_i (
    .clock     (clock),
    .reset     (reset),
    .req_read  (core_read),
    .req_write (core_write),
    .busy      (1'b0),
    .rd_issue  (core_read),
    .rd_resp   (core_resp_valid)
);

// ==== source/mem_subsystem.sv ====
module mem_subsystem #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                clock,
    input  logic                reset,

    // instruction side
    input  logic                instr_read,
    input  logic                instr_write,
    input  mem_pkg::line_addr_t instr_addr,
    input  mem_pkg::line_t      instr_wdata,
    output logic                instr_busy,
    output logic                instr_resp_valid,
    output mem_pkg::line_addr_t instr_resp_addr,
    output mem_pkg::line_t      instr_resp_data,

    // data side
    input  logic                data_read,
    input  logic                data_write,
    input  mem_pkg::line_addr_t data_addr,
    input  mem_pkg::line_t      data_wdata,
    output logic                data_busy,
    output logic                data_resp_valid,
    output mem_pkg::line_addr_t data_resp_addr,
    output mem_pkg::line_t      data_resp_data
);

    // mux to bus delay
    mem_pkg::requester_id_t bus_req_id;
    logic                   bus_req_read;
    logic                   bus_req_write;
    mem_pkg::line_addr_t    bus_req_addr;
    mem_pkg::line_t         bus_req_data;

    // bus delay to core and back
    logic                   core_read;
    logic                   core_write;
    mem_pkg::line_addr_t    core_addr;
    mem_pkg::line_t         core_wdata;
    logic                   core_resp_valid;
    mem_pkg::line_addr_t    core_resp_addr;
    mem_pkg::line_t         core_resp_data;

    // bus delay to mux
    mem_pkg::requester_id_t bus_resp_id;
    logic                   bus_resp_valid;
    mem_pkg::line_addr_t    bus_resp_addr;
    mem_pkg::line_t         bus_resp_data;

    mem_port_mux mem_port_mux_i (.*);

    mem_bus_delay #(
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_bus_delay_i (.*);

    mem_core mem_core_i (.*);

endmodule

// ==== source/mem_core.sv ====
module mem_core (
    input  logic                clock,
    input  logic                reset,

    input  logic                core_read,
    input  logic                core_write,
    input  mem_pkg::line_addr_t core_addr,
    input  mem_pkg::line_t      core_wdata,

    output logic                core_resp_valid,
    output mem_pkg::line_addr_t core_resp_addr,
    output mem_pkg::line_t      core_resp_data
);

    // one entry per line address
    mem_pkg::line_t mem_array [mem_pkg::line_count];

    // read response valid one cycle after the read
    always_ff @(posedge clock) begin
        if (reset) begin
            core_resp_valid <= 1'b0;
        end else begin
            core_resp_valid <= core_read;
        end
    end

    always_ff @(posedge clock) begin
        if (core_write) begin
            mem_array[core_addr] <= core_wdata;  // visible to the next read
        end
        if (core_read) begin
            core_resp_addr <= core_addr;  // address echoed with the line
            core_resp_data <= mem_array[core_addr];
        end
    end

endmodule

// ==== source/mem_bus_delay.sv ====
module mem_bus_delay #(
    parameter int MEM_LATENCY = 3
) (
    input  logic                   clock,
    input  logic                   reset,

    input  mem_pkg::requester_id_t bus_req_id,
    input  logic                   bus_req_read,
    input  logic                   bus_req_write,
    input  mem_pkg::line_addr_t    bus_req_addr,
    input  mem_pkg::line_t         bus_req_data,

    output logic                   core_read,
    output logic                   core_write,
    output mem_pkg::line_addr_t    core_addr,
    output mem_pkg::line_t         core_wdata,

    input  logic                   core_resp_valid,
    input  mem_pkg::line_addr_t    core_resp_addr,
    input  mem_pkg::line_t         core_resp_data,

    output mem_pkg::requester_id_t bus_resp_id,
    output logic                   bus_resp_valid,
    output mem_pkg::line_addr_t    bus_resp_addr,
    output mem_pkg::line_t         bus_resp_data
);

    // request direction, stage 0 is nearest the port mux
    mem_pkg::requester_id_t req_id_q    [MEM_LATENCY];
    logic                   req_read_q  [MEM_LATENCY];
    logic                   req_write_q [MEM_LATENCY];
    mem_pkg::line_addr_t    req_addr_q  [MEM_LATENCY];
    mem_pkg::line_t         req_data_q  [MEM_LATENCY];

    // response direction, stage 0 is nearest the core
    mem_pkg::requester_id_t resp_id_q    [MEM_LATENCY];
    logic                   resp_valid_q [MEM_LATENCY];
    mem_pkg::line_addr_t    resp_addr_q  [MEM_LATENCY];
    mem_pkg::line_t         resp_data_q  [MEM_LATENCY];

    mem_pkg::requester_id_t core_id_q;  // id of the request the core is serving

    assign core_read  = req_read_q[MEM_LATENCY-1];
    assign core_write = req_write_q[MEM_LATENCY-1];
    assign core_addr  = req_addr_q[MEM_LATENCY-1];
    assign core_wdata = req_data_q[MEM_LATENCY-1];

    assign bus_resp_id    = resp_id_q[MEM_LATENCY-1];
    assign bus_resp_valid = resp_valid_q[MEM_LATENCY-1];
    assign bus_resp_addr  = resp_addr_q[MEM_LATENCY-1];
    assign bus_resp_data  = resp_data_q[MEM_LATENCY-1];

    // strobes and valids
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                req_read_q[i]   <= 1'b0;
                req_write_q[i]  <= 1'b0;
                resp_valid_q[i] <= 1'b0;
            end
        end else begin
            req_read_q[0]   <= bus_req_read;
            req_write_q[0]  <= bus_req_write;
            resp_valid_q[0] <= core_resp_valid;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                req_read_q[i]   <= req_read_q[i-1];
                req_write_q[i]  <= req_write_q[i-1];
                resp_valid_q[i] <= resp_valid_q[i-1];
            end
        end
    end

    // payload shifts every cycle
    always_ff @(posedge clock) begin
        req_id_q[0]   <= bus_req_id;
        req_addr_q[0] <= bus_req_addr;
        req_data_q[0] <= bus_req_data;
        core_id_q     <= req_id_q[MEM_LATENCY-1];  // matches the core's read cycle
        resp_id_q[0]   <= core_id_q;
        resp_addr_q[0] <= core_resp_addr;
        resp_data_q[0] <= core_resp_data;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            req_id_q[i]    <= req_id_q[i-1];
            req_addr_q[i]  <= req_addr_q[i-1];
            req_data_q[i]  <= req_data_q[i-1];
            resp_id_q[i]   <= resp_id_q[i-1];
            resp_addr_q[i] <= resp_addr_q[i-1];
            resp_data_q[i] <= resp_data_q[i-1];
        end
    end

endmodule

// ==== source/mem_port_mux.sv ====
module mem_port_mux (
    input  logic                   clock,
    input  logic                   reset,

    input  logic                   instr_read,
    input  logic                   instr_write,
    input  mem_pkg::line_addr_t    instr_addr,
    input  mem_pkg::line_t         instr_wdata,
    input  logic                   data_read,
    input  logic                   data_write,
    input  mem_pkg::line_addr_t    data_addr,
    input  mem_pkg::line_t         data_wdata,
    output logic                   instr_busy,
    output logic                   data_busy,

    output mem_pkg::requester_id_t bus_req_id,
    output logic                   bus_req_read,
    output logic                   bus_req_write,
    output mem_pkg::line_addr_t    bus_req_addr,
    output mem_pkg::line_t         bus_req_data,

    input  mem_pkg::requester_id_t bus_resp_id,
    input  logic                   bus_resp_valid,
    input  mem_pkg::line_addr_t    bus_resp_addr,
    input  mem_pkg::line_t         bus_resp_data,

    output logic                   instr_resp_valid,
    output mem_pkg::line_addr_t    instr_resp_addr,
    output mem_pkg::line_t         instr_resp_data,
    output logic                   data_resp_valid,
    output mem_pkg::line_addr_t    data_resp_addr,
    output mem_pkg::line_t         data_resp_data
);

    logic                   data_strobe;
    logic                   instr_strobe;
    logic                   hold_read;     // instruction request lost arbitration
    logic                   hold_write;
    logic                   hold_valid;
    mem_pkg::line_addr_t    hold_addr;
    mem_pkg::line_t         hold_data;

    mem_pkg::requester_id_t next_id;
    logic                   next_read;
    logic                   next_write;
    mem_pkg::line_addr_t    next_addr;
    mem_pkg::line_t         next_data;

    assign data_strobe  = data_read | data_write;
    assign instr_strobe = instr_read | instr_write;
    assign hold_valid   = hold_read | hold_write;

    assign instr_busy = hold_valid;
    assign data_busy  = 1'b0;  // data side always wins

    // pick data, then held instruction, then new instruction
    always_comb begin
        next_id    = mem_pkg::data_id;
        next_read  = data_read;
        next_write = data_write;
        next_addr  = data_addr;
        next_data  = data_wdata;
        if (!data_strobe && hold_valid) begin
            next_id    = mem_pkg::instr_id;
            next_read  = hold_read;
            next_write = hold_write;
            next_addr  = hold_addr;
            next_data  = hold_data;
        end else if (!data_strobe) begin
            next_id    = mem_pkg::instr_id;
            next_read  = instr_read;
            next_write = instr_write;
            next_addr  = instr_addr;
            next_data  = instr_wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_read     <= 1'b0;
            hold_write    <= 1'b0;
            bus_req_read  <= 1'b0;
            bus_req_write <= 1'b0;
        end else begin
            if (!hold_valid && data_strobe && instr_strobe) begin
                hold_read  <= instr_read;   // park the loser
                hold_write <= instr_write;
            end else if (hold_valid && !data_strobe) begin
                hold_read  <= 1'b0;         // issued this cycle
                hold_write <= 1'b0;
            end
            bus_req_read  <= next_read;
            bus_req_write <= next_write;
        end
    end

    always_ff @(posedge clock) begin
        if (!hold_valid && instr_strobe) begin
            hold_addr <= instr_addr;
            hold_data <= instr_wdata;
        end
        bus_req_id   <= next_id;
        bus_req_addr <= next_addr;
        bus_req_data <= next_data;
    end

    // responses steered by id, payload shared
    assign instr_resp_valid = bus_resp_valid && (bus_resp_id == mem_pkg::instr_id);
    assign data_resp_valid  = bus_resp_valid && (bus_resp_id == mem_pkg::data_id);
    assign instr_resp_addr  = bus_resp_addr;
    assign instr_resp_data  = bus_resp_data;
    assign data_resp_addr   = bus_resp_addr;
    assign data_resp_data   = bus_resp_data;

endmodule

// ==== source/mem_pkg.sv ====
package mem_pkg;

    // line geometry
    parameter int line_width      = 128;  // bits per memory line
    parameter int line_addr_width = 8;    // line index width
    parameter int line_count      = 2 ** line_addr_width;

    // one memory line as it travels on the bus
    typedef logic [line_width-1:0] line_t;

    // index of a line in the memory core
    typedef logic [line_addr_width-1:0] line_addr_t;

    // requester that issued a request, carried back with its response
    typedef logic [0:0] requester_id_t;

    parameter requester_id_t instr_id = 1'b0;  // instruction side
    parameter requester_id_t data_id  = 1'b1;  // data side

endpackage
